/* source/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

  parameter int unsigned addr_width = 32;
  parameter int unsigned data_width = 32;
  parameter int unsigned be_width   = data_width / 8;

  // Forward half of every link as driven by the initiator
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [addr_width-1:0] add;
    logic [data_width-1:0] wdata;
    logic [be_width-1:0]   be;
  } bus_req_t;

  // Return half with gnt in the request cycle and r_valid later
  typedef struct packed {
    logic                  gnt;
    logic                  r_valid;
    logic [data_width-1:0] r_rdata;
    logic                  r_err;
  } bus_rsp_t;

endpackage

`default_nettype wire

/* source/cluster_map_pkg.sv */
`default_nettype none

package cluster_map_pkg;

  // Each cluster owns a 4 MiB window
  parameter int unsigned window_shift = 22;

  // Offsets inside the window
  parameter logic [window_shift-1:0] tcdm_limit   = 22'h20_0000;
  parameter logic [window_shift-1:0] periph_base  = 22'h20_0000;
  parameter logic [window_shift-1:0] periph_limit = 22'h20_0800;

  // Low selects the event unit, high selects DMA control
  parameter int unsigned eu_select_bit = 10;

  parameter logic [31:0] err_rdata = 32'hBADA_CCE5;

  typedef enum logic [1:0] {
    route_tcdm,
    route_soc,
    route_periph,
    route_err
  } core_route_e;

  typedef enum logic {
    route_eu,
    route_dma
  } periph_route_e;

endpackage

`default_nettype wire

/* source/resp_route_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module resp_route_fifo #(
  parameter type         tag_t = logic,
  parameter int unsigned Depth = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  tag_t tag_i,
  input  logic pop_i,
  output tag_t head_o,
  output tag_t last_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  tag_t                mem_q [Depth];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] last_ptr;
  logic [CntWidth-1:0] count_q;
  logic                push_en;
  logic                pop_en;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));
  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && !empty_o;

  // Slot behind the write pointer holds the newest tag
  assign last_ptr = (wr_ptr_q == '0) ? PtrWidth'(Depth - 1) : wr_ptr_q - 1'b1;
  assign head_o   = mem_q[rd_ptr_q];
  assign last_o   = mem_q[last_ptr];

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/core_data_demux.sv */
`timescale 1ns/100ps
`default_nettype none

module core_data_demux #(
  parameter int unsigned RemapAddress   = 1,
  parameter int unsigned ClustAlias     = 1,
  parameter int unsigned ClustAliasBase = 'h040,
  parameter int unsigned Depth          = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [3:0]              base_addr_i,
  input  logic [5:0]              cluster_id_i,
  input  core_bus_pkg::bus_req_t  core_req_i,
  output core_bus_pkg::bus_rsp_t  core_rsp_o,
  output core_bus_pkg::bus_req_t  tcdm_req_o,
  input  core_bus_pkg::bus_rsp_t  tcdm_rsp_i,
  output core_bus_pkg::bus_req_t  soc_req_o,
  input  core_bus_pkg::bus_rsp_t  soc_rsp_i,
  output core_bus_pkg::bus_req_t  periph_req_o,
  input  core_bus_pkg::bus_rsp_t  periph_rsp_i
);

  localparam int unsigned OffWidth   = cluster_map_pkg::window_shift;
  localparam int unsigned AliasWidth = core_bus_pkg::addr_width - OffWidth;

  logic [OffWidth-1:0]          offset;
  logic                         in_own;
  logic                         in_alias;
  logic                         route_ok;
  logic                         target_gnt;
  logic                         core_gnt;
  logic                         err_valid_q;
  logic                         rsp_valid;
  logic                         fifo_empty;
  logic                         fifo_full;
  cluster_map_pkg::core_route_e route;
  cluster_map_pkg::core_route_e fifo_head;
  cluster_map_pkg::core_route_e fifo_last;
  core_bus_pkg::bus_rsp_t       sel_rsp;

  assign offset   = core_req_i.add[OffWidth-1:0];
  assign in_own   = (core_req_i.add[31:28] == base_addr_i) &&
                    (core_req_i.add[27:OffWidth] == cluster_id_i);
  assign in_alias = (ClustAlias != 0) &&
                    (core_req_i.add[31:OffWidth] == AliasWidth'(ClustAliasBase));

  always_comb begin
    if (!(in_own || in_alias)) begin
      route = cluster_map_pkg::route_soc;
    end else if (offset < cluster_map_pkg::tcdm_limit) begin
      route = cluster_map_pkg::route_tcdm;
    end else if (offset >= cluster_map_pkg::periph_base &&
                 offset < cluster_map_pkg::periph_limit) begin
      route = cluster_map_pkg::route_periph;
    end else begin
      route = cluster_map_pkg::route_err;
    end
  end

  // Only one target may hold outstanding responses at a time
  assign route_ok = !fifo_full && (fifo_empty || fifo_last == route);

  always_comb begin
    case (route)
      cluster_map_pkg::route_tcdm:   target_gnt = tcdm_rsp_i.gnt;
      cluster_map_pkg::route_soc:    target_gnt = soc_rsp_i.gnt;
      cluster_map_pkg::route_periph: target_gnt = periph_rsp_i.gnt;
      default:                       target_gnt = 1'b1;
    endcase
  end

  assign core_gnt = core_req_i.req && route_ok && target_gnt;

  always_comb begin
    tcdm_req_o       = core_req_i;
    soc_req_o        = core_req_i;
    periph_req_o     = core_req_i;
    tcdm_req_o.req   = core_req_i.req && route_ok && (route == cluster_map_pkg::route_tcdm);
    soc_req_o.req    = core_req_i.req && route_ok && (route == cluster_map_pkg::route_soc);
    periph_req_o.req = core_req_i.req && route_ok && (route == cluster_map_pkg::route_periph);
    if (RemapAddress != 0) begin
      tcdm_req_o.add = core_bus_pkg::addr_width'(offset);
    end
  end

  // Error responder answers one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= core_gnt && (route == cluster_map_pkg::route_err);
    end
  end

  always_comb begin
    case (fifo_head)
      cluster_map_pkg::route_tcdm:   sel_rsp = tcdm_rsp_i;
      cluster_map_pkg::route_soc:    sel_rsp = soc_rsp_i;
      cluster_map_pkg::route_periph: sel_rsp = periph_rsp_i;
      default: begin
        sel_rsp.gnt     = 1'b1;
        sel_rsp.r_valid = err_valid_q;
        sel_rsp.r_rdata = cluster_map_pkg::err_rdata;
        sel_rsp.r_err   = 1'b1;
      end
    endcase
  end

  assign rsp_valid = sel_rsp.r_valid && !fifo_empty;

  always_comb begin
    core_rsp_o.gnt     = core_gnt;
    core_rsp_o.r_valid = rsp_valid;
    core_rsp_o.r_rdata = sel_rsp.r_rdata;
    core_rsp_o.r_err   = sel_rsp.r_err && rsp_valid;
  end

  resp_route_fifo #(
    .tag_t (cluster_map_pkg::core_route_e),
    .Depth (Depth)
  ) route_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (core_gnt),
    .tag_i   (route),
    .pop_i   (rsp_valid),
    .head_o  (fifo_head),
    .last_o  (fifo_last),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

endmodule

`default_nettype wire

/* source/periph_demux.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_demux #(
  parameter int unsigned Depth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  core_bus_pkg::bus_req_t periph_req_i,
  output core_bus_pkg::bus_rsp_t periph_rsp_o,
  output core_bus_pkg::bus_req_t eu_req_o,
  input  core_bus_pkg::bus_rsp_t eu_rsp_i,
  output core_bus_pkg::bus_req_t dma_req_o,
  input  core_bus_pkg::bus_rsp_t dma_rsp_i
);

  cluster_map_pkg::periph_route_e route;
  cluster_map_pkg::periph_route_e fifo_head;
  cluster_map_pkg::periph_route_e fifo_last;
  logic                           fifo_empty;
  logic                           fifo_full;
  logic                           route_ok;
  logic                           up_gnt;
  core_bus_pkg::bus_rsp_t         sel_rsp;
  logic                           rsp_valid;

  assign route    = cluster_map_pkg::periph_route_e'(
                      periph_req_i.add[cluster_map_pkg::eu_select_bit]);
  assign route_ok = !fifo_full && (fifo_empty || fifo_last == route);

  always_comb begin
    eu_req_o      = periph_req_i;
    dma_req_o     = periph_req_i;
    eu_req_o.req  = periph_req_i.req && route_ok && (route == cluster_map_pkg::route_eu);
    dma_req_o.req = periph_req_i.req && route_ok && (route == cluster_map_pkg::route_dma);
  end

  assign up_gnt = periph_req_i.req && route_ok &&
                  ((route == cluster_map_pkg::route_eu) ? eu_rsp_i.gnt : dma_rsp_i.gnt);

  // Return path follows the oldest outstanding tag
  assign sel_rsp   = (fifo_head == cluster_map_pkg::route_eu) ? eu_rsp_i : dma_rsp_i;
  assign rsp_valid = sel_rsp.r_valid && !fifo_empty;

  always_comb begin
    periph_rsp_o.gnt     = up_gnt;
    periph_rsp_o.r_valid = rsp_valid;
    periph_rsp_o.r_rdata = sel_rsp.r_rdata;
    periph_rsp_o.r_err   = sel_rsp.r_err && rsp_valid;
  end

  resp_route_fifo #(
    .tag_t (cluster_map_pkg::periph_route_e),
    .Depth (Depth)
  ) route_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (up_gnt),
    .tag_i   (route),
    .pop_i   (rsp_valid),
    .head_o  (fifo_head),
    .last_o  (fifo_last),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

endmodule

`default_nettype wire

/* source/ext_access_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_access_monitor (
  input  core_bus_pkg::bus_req_t soc_req_i,
  input  core_bus_pkg::bus_rsp_t soc_rsp_i,
  output logic [3:0]             ext_perf_o
);

  logic load_req;
  logic store_req;
  logic load_done;
  logic store_done;
  logic load_wait;
  logic store_wait;

  assign load_req  = soc_req_i.req && !soc_req_i.we;
  assign store_req = soc_req_i.req && soc_req_i.we;

  // Transfers complete on the grant cycle
  assign load_done  = load_req && soc_rsp_i.gnt;
  assign store_done = store_req && soc_rsp_i.gnt;

  // Stall cycles seen by the core
  assign load_wait  = load_req && !soc_rsp_i.gnt;
  assign store_wait = store_req && !soc_rsp_i.gnt;

  assign ext_perf_o = {store_wait, load_wait, store_done, load_done};

endmodule

`default_nettype wire

/* source/core_demux_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_demux_top #(
  parameter int unsigned RemapAddress   = 1,
  parameter int unsigned ClustAlias     = 1,
  parameter int unsigned ClustAliasBase = 'h040,
  parameter int unsigned Depth          = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [3:0]             base_addr_i,
  input  logic [5:0]             cluster_id_i,
  input  core_bus_pkg::bus_req_t core_req_i,
  output core_bus_pkg::bus_rsp_t core_rsp_o,
  output core_bus_pkg::bus_req_t tcdm_req_o,
  input  core_bus_pkg::bus_rsp_t tcdm_rsp_i,
  output core_bus_pkg::bus_req_t soc_req_o,
  input  core_bus_pkg::bus_rsp_t soc_rsp_i,
  output core_bus_pkg::bus_req_t eu_req_o,
  input  core_bus_pkg::bus_rsp_t eu_rsp_i,
  output core_bus_pkg::bus_req_t dma_req_o,
  input  core_bus_pkg::bus_rsp_t dma_rsp_i,
  output logic [3:0]             ext_perf_o
);

  // Link between the two routers
  core_bus_pkg::bus_req_t periph_req;
  core_bus_pkg::bus_rsp_t periph_rsp;

  core_data_demux #(
    .RemapAddress   (RemapAddress),
    .ClustAlias     (ClustAlias),
    .ClustAliasBase (ClustAliasBase),
    .Depth          (Depth)
  ) core_data_demux_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .base_addr_i  (base_addr_i),
    .cluster_id_i (cluster_id_i),
    .core_req_i   (core_req_i),
    .core_rsp_o   (core_rsp_o),
    .tcdm_req_o   (tcdm_req_o),
    .tcdm_rsp_i   (tcdm_rsp_i),
    .soc_req_o    (soc_req_o),
    .soc_rsp_i    (soc_rsp_i),
    .periph_req_o (periph_req),
    .periph_rsp_i (periph_rsp)
  );

  periph_demux #(
    .Depth (Depth)
  ) periph_demux_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .periph_req_i (periph_req),
    .periph_rsp_o (periph_rsp),
    .eu_req_o     (eu_req_o),
    .eu_rsp_i     (eu_rsp_i),
    .dma_req_o    (dma_req_o),
    .dma_rsp_i    (dma_rsp_i)
  );

  ext_access_monitor ext_access_monitor_i (
    .soc_req_i  (soc_req_o),
    .soc_rsp_i  (soc_rsp_i),
    .ext_perf_o (ext_perf_o)
  );

endmodule

`default_nettype wire

/* tests/core_demux_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module core_demux_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input core_bus_pkg::bus_req_t core_req_i,
  input core_bus_pkg::bus_rsp_t core_rsp_i,
  input logic [3:0]             target_req_i,
  input logic [3:0]             ext_perf_i
);

  int unsigned assert_fails = 0;

  // A stalled core request keeps every field until its grant
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_req_i.req && !core_rsp_i.gnt |=> $stable(core_req_i))
    else begin
      $error("core request changed before it was granted");
      assert_fails++;
    end

  one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(target_req_i))
    else begin
      $error("more than one target request active");
      assert_fails++;
    end

  perf_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (ext_perf_i == 4'b0))
    else begin
      $error("ext_perf_o not zero during reset");
      assert_fails++;
    end

endmodule

bind core_demux_top core_demux_checker checker_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .core_req_i   (core_req_i),
  .core_rsp_i   (core_rsp_o),
  .target_req_i ({dma_req_o.req, eu_req_o.req, soc_req_o.req, tcdm_req_o.req}),
  .ext_perf_i   (ext_perf_o)
);

`default_nettype wire

/* tests/core_demux_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_demux_tb;

  localparam int MaxStim  = 64;
  localparam int NumTgt   = 4;
  localparam int RouteSoc = 1;
  localparam int RouteErr = 4;
  localparam logic [31:0] ErrData = 32'hBADA_CCE5;
  localparam logic [31:0] TgtXor [NumTgt] = '{
    32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'h4444_4444
  };

  // Target response waiting for its release cycle
  typedef struct packed {
    logic [1:0]  tgt;
    logic [31:0] rdata;
    logic [31:0] due;
  } pend_t;

  logic                   clk;
  logic                   rst_n;
  logic [3:0]             base_addr;
  logic [5:0]             cluster_id;
  core_bus_pkg::bus_req_t core_req;
  core_bus_pkg::bus_rsp_t core_rsp;
  core_bus_pkg::bus_req_t tgt_req [NumTgt];
  core_bus_pkg::bus_rsp_t tgt_rsp [NumTgt];
  logic [3:0]             ext_perf;

  logic        stim_we    [MaxStim];
  logic [31:0] stim_addr  [MaxStim];
  logic [31:0] stim_wdata [MaxStim];
  logic [3:0]  stim_be    [MaxStim];
  int          stim_route [MaxStim];
  int          grant_tick [MaxStim];
  int          n_stim;
  logic        stim_ready;

  logic [15:0] lfsr;
  pend_t       pend_q [$];
  int          exp_q [$];
  int          tick;
  int          n_grants;
  int          n_rsps;
  int          data_errs;
  int          proto_errs;
  int          chk_fails;
  int          soc_gnt [2];
  int          soc_wait [2];
  int          perf_cnt [4];

  core_demux_top #(
    .RemapAddress   (1),
    .ClustAlias     (1),
    .ClustAliasBase ('h040),
    .Depth          (4)
  ) DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .base_addr_i  (base_addr),
    .cluster_id_i (cluster_id),
    .core_req_i   (core_req),
    .core_rsp_o   (core_rsp),
    .tcdm_req_o   (tgt_req[0]),
    .tcdm_rsp_i   (tgt_rsp[0]),
    .soc_req_o    (tgt_req[1]),
    .soc_rsp_i    (tgt_rsp[1]),
    .eu_req_o     (tgt_req[2]),
    .eu_rsp_i     (tgt_rsp[2]),
    .dma_req_o    (tgt_req[3]),
    .dma_rsp_i    (tgt_rsp[3]),
    .ext_perf_o   (ext_perf)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic take_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
    return b;
  endfunction

  // TCDM only sees the offset inside the cluster window
  function automatic logic [31:0] link_addr(input logic [31:0] addr, input int route);
    if (route == 0) begin
      return {10'b0, addr[21:0]};
    end
    return addr;
  endfunction

  function automatic string link_name(input int t);
    case (t)
      0:       return "tcdm_req_o";
      1:       return "soc_req_o";
      2:       return "eu_req_o";
      default: return "dma_req_o";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error: %s (cycle %0d)", what, tick);
      proto_errs++;
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] be;
    logic [31:0] route;
    n_stim = 0;
    fd = $fopen("tests/core_demux_stim.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%h %h %h %h %h", op, addr, wdata, be, route);
      if (cnt == 5 && n_stim < MaxStim) begin
        stim_we[n_stim]    = op[0];
        stim_addr[n_stim]  = addr;
        stim_wdata[n_stim] = wdata;
        stim_be[n_stim]    = be[3:0];
        stim_route[n_stim] = int'(route);
        n_stim++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_targets();
    int t;
    int i;
    for (t = 0; t < NumTgt; t++) begin
      tgt_rsp[t].gnt     = take_bit();
      tgt_rsp[t].r_valid = 1'b0;
      tgt_rsp[t].r_rdata = '0;
      tgt_rsp[t].r_err   = 1'b0;
      // Each target answers in grant order
      for (i = 0; i < pend_q.size(); i++) begin
        if (pend_q[i].tgt == 2'(t)) begin
          if (pend_q[i].due <= 32'(tick)) begin
            tgt_rsp[t].r_valid = 1'b1;
            tgt_rsp[t].r_rdata = pend_q[i].rdata;
            pend_q.delete(i);
          end
          break;
        end
      end
    end
  endtask

  task automatic accept_targets();
    int    t;
    int    lat;
    pend_t p;
    for (t = 0; t < NumTgt; t++) begin
      if (tgt_req[t].req && tgt_rsp[t].gnt) begin
        lat     = int'(take_bit());
        lat     = lat * 2 + int'(take_bit());
        lat     = 1 + lat % 3;
        p.tgt   = 2'(t);
        p.rdata = tgt_req[t].add ^ TgtXor[t];
        p.due   = 32'(tick + lat);
        pend_q.push_back(p);
      end
    end
  endtask

  task automatic check_request(input int idx);
    int t;
    int r;
    r = stim_route[idx];
    for (t = 0; t < NumTgt; t++) begin
      if (t != r) begin
        check_true(!tgt_req[t].req,
                   $sformatf("%s raised for transaction %0d", link_name(t), idx));
      end
    end
    // SoC access presented on its link and still stalled by the core grant
    if (r == RouteSoc && tgt_req[r].req && !core_rsp.gnt) begin
      soc_wait[stim_we[idx]]++;
    end
    if (!core_rsp.gnt) begin
      return;
    end
    if (r != RouteErr) begin
      check_true(tgt_req[r].req,
                 $sformatf("granted transaction %0d never reached its target", idx));
      check_value({link_name(r), ".add"}, tgt_req[r].add, link_addr(stim_addr[idx], r));
      check_value({link_name(r), ".wdata"}, tgt_req[r].wdata, stim_wdata[idx]);
      check_value({link_name(r), ".be"}, 32'(tgt_req[r].be), 32'(stim_be[idx]));
      check_value({link_name(r), ".we"}, 32'(tgt_req[r].we), 32'(stim_we[idx]));
    end
    if (r == RouteSoc) begin
      soc_gnt[stim_we[idx]]++;
    end
    grant_tick[idx] = tick;
    exp_q.push_back(idx);
    n_grants++;
  endtask

  task automatic check_idle();
    int t;
    for (t = 0; t < NumTgt; t++) begin
      check_true(!tgt_req[t].req, $sformatf("%s raised while the core is idle", link_name(t)));
    end
  endtask

  task automatic check_response();
    int          idx;
    logic [31:0] exp_data;
    if (!core_rsp.r_valid) begin
      return;
    end
    n_rsps++;
    if (exp_q.size() == 0) begin
      check_true(1'b0, "response arrived with nothing outstanding");
      return;
    end
    idx = exp_q.pop_front();
    if (stim_route[idx] == RouteErr) begin
      check_value("core_rsp_o.r_err", 32'(core_rsp.r_err), 32'd1);
      check_value("core_rsp_o.r_rdata", core_rsp.r_rdata, ErrData);
      check_true(tick == grant_tick[idx] + 1,
                 $sformatf("error response %0d not one cycle after its grant", idx));
    end else begin
      check_value("core_rsp_o.r_err", 32'(core_rsp.r_err), 32'd0);
      if (!stim_we[idx]) begin
        exp_data = link_addr(stim_addr[idx], stim_route[idx]) ^ TgtXor[stim_route[idx]];
        check_value("core_rsp_o.r_rdata", core_rsp.r_rdata, exp_data);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    wait (stim_ready === 1'b1);
    repeat (200 * n_stim + 8) @(posedge clk);
    $display("Error: timeout, transactions still pending after %0d cycles", tick);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int   k;
    int   next_idx;
    int   cur_idx;
    logic holding;
    rst_n      = 1'b0;
    base_addr  = 4'h1;
    cluster_id = 6'd3;
    core_req   = '0;
    for (k = 0; k < NumTgt; k++) begin
      tgt_rsp[k] = '0;
    end
    lfsr       = 16'd24;
    stim_ready = 1'b0;
    tick       = 0;
    n_grants   = 0;
    n_rsps     = 0;
    data_errs  = 0;
    proto_errs = 0;
    soc_gnt    = '{0, 0};
    soc_wait   = '{0, 0};
    perf_cnt   = '{0, 0, 0, 0};
    next_idx   = 0;
    cur_idx    = 0;
    holding    = 1'b0;
    load_stim();
    if (n_stim == 0) begin
      $display("Error: no stimulus could be read from tests/core_demux_stim.txt");
      $display("** FAIL **");
    end else begin
      stim_ready = 1'b1;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      while (next_idx < n_stim || holding || exp_q.size() != 0) begin
        @(negedge clk);
        tick++;
        drive_targets();
        if (!holding && next_idx < n_stim) begin
          core_req.req   = 1'b1;
          core_req.we    = stim_we[next_idx];
          core_req.add   = stim_addr[next_idx];
          core_req.wdata = stim_wdata[next_idx];
          core_req.be    = stim_be[next_idx];
          cur_idx        = next_idx;
          next_idx++;
          holding        = 1'b1;
        end else if (!holding) begin
          core_req = '0;
        end
        // Sample just before the rising edge
        #4;
        check_response();
        accept_targets();
        if (holding) begin
          check_request(cur_idx);
          if (core_rsp.gnt) begin
            holding = 1'b0;
          end
        end else begin
          check_idle();
        end
        for (k = 0; k < 4; k++) begin
          if (ext_perf[k]) begin
            perf_cnt[k]++;
          end
        end
      end
      // Idle cycles catch late or duplicate responses
      repeat (8) begin
        @(negedge clk);
        tick++;
        drive_targets();
        #4;
        check_response();
        check_idle();
        for (k = 0; k < 4; k++) begin
          if (ext_perf[k]) begin
            perf_cnt[k]++;
          end
        end
      end
      check_true(n_rsps == n_grants, "response count differs from grant count");
      check_value("ext_perf_o[0] pulses", 32'(perf_cnt[0]), 32'(soc_gnt[0]));
      check_value("ext_perf_o[1] pulses", 32'(perf_cnt[1]), 32'(soc_gnt[1]));
      check_value("ext_perf_o[2] pulses", 32'(perf_cnt[2]), 32'(soc_wait[0]));
      check_value("ext_perf_o[3] pulses", 32'(perf_cnt[3]), 32'(soc_wait[1]));
      chk_fails = int'(DUT.checker_i.assert_fails);
      $display("Errors: %0d data, %0d protocol, %0d assertion over %0d transactions",
               data_errs, proto_errs, chk_fails, n_stim);
      if (data_errs + proto_errs + chk_fails == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/core_demux_stim.txt */
# op addr wdata be route, all hex
# op 0 read 1 write, route 0 tcdm 1 soc 2 event unit 3 dma 4 error
0 10C00010 00000000 F 0
1 10C00020 A5A5A5A5 F 0
0 10000100 00000000 F 0
0 101FFFFC 00000000 F 0
0 1A100000 00000000 F 1
1 1A100004 12345678 3 1
0 11000000 00000000 F 1
0 10E00000 00000000 F 2
1 10E00040 0000BEEF C 2
0 10E00400 00000000 F 3
1 10E007FC CAFEF00D F 3
0 10E00800 00000000 F 4
1 10F00000 DEADBEEF F 4
0 10300000 00000000 F 4
0 10C00030 00000000 F 0
0 20000000 00000000 F 1
1 20000004 00C0FFEE F 1
0 10E00404 00000000 F 3

/* sim.f */
source/core_bus_pkg.sv
source/cluster_map_pkg.sv
source/resp_route_fifo.sv
source/core_data_demux.sv
source/periph_demux.sv
source/ext_access_monitor.sv
source/core_demux_top.sv
tests/core_demux_checker.sv
tests/core_demux_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_demux_tb -f sim.f -o sim_tb \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true

grep -qxF '** PASS **' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
